// File: design/banner_pkg.sv
/* Banner renderer package
   Coordinate and glyph widths, banner geometry and the pipeline payload structs */
`default_nettype none

package banner_pkg;

  // Widths with a meaning of their own
  typedef logic [1:0]  glyph_code_t;
  typedef logic [1:0]  slot_t;
  typedef logic [6:0]  coord_x_t;
  typedef logic [4:0]  coord_y_t;
  typedef logic [4:0]  glyph_idx_t;
  typedef logic [15:0] lit_count_t;

  // Geometry of one glyph and of the whole banner
  localparam int GLYPH_SIZE = 20;
  localparam int NUM_SLOTS  = 4;
  localparam int BANNER_W   = 80;

  // Code 2 has no bitmap and renders as an empty glyph
  localparam glyph_code_t CODE_BLANK = 2'd2;

  // Pixel request from the host
  typedef struct packed {
    coord_x_t x;
    coord_y_t y;
  } pix_req_t;

  // Decoded request handed to the execute stage
  typedef struct packed {
    coord_x_t   x;
    coord_y_t   y;
    slot_t      slot;
    glyph_idx_t col;
    glyph_idx_t row;
    logic       in_range;
  } pix_dec_t;

  // Rendered pixel
  typedef struct packed {
    coord_x_t x;
    coord_y_t y;
    logic     lit;
  } pix_res_t;

  // One layout slot write
  typedef struct packed {
    slot_t       slot;
    glyph_code_t code;
  } layout_wr_t;

endpackage

`default_nettype wire

// File: design/glyph_rom.sv
/* Glyph ROM
   Combinational 20x20 bitmaps for codes 0, 1 and 3, one pixel per lookup */
`default_nettype none

module glyph_rom (
  input  banner_pkg::glyph_idx_t  row,
  input  banner_pkg::glyph_idx_t  col,
  input  banner_pkg::glyph_code_t select,
  output logic                    word
);

  logic [19:0] line_c0;
  logic [19:0] line_c1;
  logic [19:0] line_c3;
  logic [19:0] line;
  banner_pkg::glyph_idx_t bit_idx;

  // Code 0 bitmap, MSB is the leftmost column
  always_comb begin
    unique case (row)
      5'd1:    line_c0 = 20'b00000111111111100000;
      5'd2:    line_c0 = 20'b00011000000000011000;
      5'd3:    line_c0 = 20'b00100000000000000100;
      5'd4:    line_c0 = 20'b01000111000011100010;
      5'd5:    line_c0 = 20'b01001000100100010010;
      5'd6:    line_c0 = 20'b01000000000000000010;
      5'd7:    line_c0 = 20'b01000100000000100010;
      5'd8:    line_c0 = 20'b00100011111111000100;
      5'd9:    line_c0 = 20'b00011000000000011000;
      5'd10:   line_c0 = 20'b00000111111111100000;
      5'd13:   line_c0 = 20'b00011111000011110000;
      5'd14:   line_c0 = 20'b00100000000100001000;
      5'd15:   line_c0 = 20'b00100000001000000100;
      5'd16:   line_c0 = 20'b00100111101000000100;
      5'd17:   line_c0 = 20'b00100011000100001000;
      5'd18:   line_c0 = 20'b00011110000011110000;
      // Rows 0, 11, 12, 19 and anything past the glyph are empty
      default: line_c0 = '0;
    endcase
  end

  // Code 1 bitmap
  always_comb begin
    unique case (row)
      5'd1:    line_c1 = 20'b00100011101110111000;
      5'd2:    line_c1 = 20'b00100010101000100000;
      5'd3:    line_c1 = 20'b00100010101110111000;
      5'd4:    line_c1 = 20'b00100010100010100000;
      5'd5:    line_c1 = 20'b00111011101110111000;
      5'd7:    line_c1 = 20'b00001110000001110000;
      5'd8:    line_c1 = 20'b00011111000011111000;
      5'd9:    line_c1 = 20'b00011111110001111000;
      5'd10:   line_c1 = 20'b00001111100111110000;
      5'd11:   line_c1 = 20'b00000011110001100000;
      5'd12:   line_c1 = 20'b00000001100001000000;
      5'd13:   line_c1 = 20'b00000000100000000000;
      5'd14:   line_c1 = 20'b00011110000000000000;
      5'd15:   line_c1 = 20'b00100000111100100100;
      5'd16:   line_c1 = 20'b00011100100010100100;
      5'd17:   line_c1 = 20'b00000010111100011100;
      5'd18:   line_c1 = 20'b00000010100010000100;
      5'd19:   line_c1 = 20'b00111100100010011000;
      default: line_c1 = '0;
    endcase
  end

  // Code 3 bitmap, every row in use
  always_comb begin
    unique case (row)
      5'd0:    line_c3 = 20'b00000000000000101010;
      5'd1:    line_c3 = 20'b00001000010000101010;
      5'd2:    line_c3 = 20'b00111100111100110110;
      5'd3:    line_c3 = 20'b01100111100110000000;
      5'd4:    line_c3 = 20'b01000011000110011100;
      5'd5:    line_c3 = 20'b00110000001100001000;
      5'd6:    line_c3 = 20'b00011100111000011100;
      5'd7:    line_c3 = 20'b00000111100000000000;
      5'd8:    line_c3 = 20'b00000011000000110100;
      5'd9:    line_c3 = 20'b00000010000000101100;
      5'd10:   line_c3 = 20'b00000000000000100100;
      5'd11:   line_c3 = 20'b00111000001110000001;
      5'd12:   line_c3 = 20'b01000100010001000001;
      5'd13:   line_c3 = 20'b01000100010001000010;
      5'd14:   line_c3 = 20'b01000100010001000010;
      5'd15:   line_c3 = 20'b01000100010001000100;
      5'd16:   line_c3 = 20'b01000100010001000100;
      5'd17:   line_c3 = 20'b01000100010001001000;
      5'd18:   line_c3 = 20'b01000100010001001000;
      5'd19:   line_c3 = 20'b00111001001110010000;
      default: line_c3 = '0;
    endcase
  end

  // Pick the line of the selected glyph, blank code gives an empty line
  always_comb begin
    if (select == banner_pkg::CODE_BLANK) begin
      line = '0;
    end else if (select == 2'd0) begin
      line = line_c0;
    end else if (select == 2'd1) begin
      line = line_c1;
    end else begin
      line = line_c3;
    end
  end

  // Column 0 sits at bit 19
  assign bit_idx = banner_pkg::glyph_idx_t'(banner_pkg::GLYPH_SIZE - 1) - col;

  assign word = (col < banner_pkg::glyph_idx_t'(banner_pkg::GLYPH_SIZE)) ?
                line[bit_idx] : 1'b0;

endmodule

`default_nettype wire

// File: design/pixel_decode.sv
/* Decode stage
   Registers a pixel request and splits x into glyph slot and column */
`default_nettype none

module pixel_decode (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req_valid,
  input  banner_pkg::pix_req_t req,
  output logic                 dec_valid,
  output banner_pkg::pix_dec_t dec
);

  banner_pkg::slot_t    slot_d;
  banner_pkg::coord_x_t base_x;
  banner_pkg::coord_x_t col_x;
  logic                 in_range_d;

  // Slot boundaries sit on multiples of the glyph width
  always_comb begin
    if (req.x < banner_pkg::coord_x_t'(banner_pkg::GLYPH_SIZE)) begin
      slot_d = 2'd0;
      base_x = '0;
    end else if (req.x < banner_pkg::coord_x_t'(2 * banner_pkg::GLYPH_SIZE)) begin
      slot_d = 2'd1;
      base_x = banner_pkg::coord_x_t'(banner_pkg::GLYPH_SIZE);
    end else if (req.x < banner_pkg::coord_x_t'(3 * banner_pkg::GLYPH_SIZE)) begin
      slot_d = 2'd2;
      base_x = banner_pkg::coord_x_t'(2 * banner_pkg::GLYPH_SIZE);
    end else begin
      slot_d = 2'd3;
      base_x = banner_pkg::coord_x_t'(3 * banner_pkg::GLYPH_SIZE);
    end
  end

  assign col_x      = req.x - base_x;
  assign in_range_d = (req.x < banner_pkg::coord_x_t'(banner_pkg::BANNER_W)) &&
                      (req.y < banner_pkg::coord_y_t'(banner_pkg::GLYPH_SIZE));

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= req_valid;
    end
  end

  // Payload, only meaningful alongside dec_valid
  always_ff @(posedge clk) begin
    dec.x        <= req.x;
    dec.y        <= req.y;
    dec.slot     <= slot_d;
    dec.col      <= banner_pkg::glyph_idx_t'(col_x);
    dec.row      <= req.y;
    dec.in_range <= in_range_d;
  end

  // In-range pixels rebuild their x from slot and column
  a_col_in_glyph: assert property (@(posedge clk) disable iff (rst)
    dec_valid && dec.in_range |->
      dec.col < banner_pkg::glyph_idx_t'(banner_pkg::GLYPH_SIZE) &&
      dec.x == banner_pkg::coord_x_t'(dec.slot * banner_pkg::GLYPH_SIZE + dec.col))
    else $error("decode: bad split x=%0d slot=%0d col=%0d", dec.x, dec.slot, dec.col);

endmodule

`default_nettype wire

// File: design/glyph_execute.sv
/* Execute stage
   Holds the four-slot layout and fetches the pixel bit from the glyph ROM */
`default_nettype none

module glyph_execute (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   cfg_valid,
  input  banner_pkg::layout_wr_t cfg,
  input  logic                   dec_valid,
  input  banner_pkg::pix_dec_t   dec,
  output logic                   exe_valid,
  output banner_pkg::pix_res_t   exe
);

  banner_pkg::glyph_code_t layout [banner_pkg::NUM_SLOTS];
  banner_pkg::glyph_code_t code;
  logic                    rom_bit;

  // Layout slots, all blank out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < banner_pkg::NUM_SLOTS; i++) begin
        layout[i] <= banner_pkg::CODE_BLANK;
      end
    end else if (cfg_valid) begin
      layout[cfg.slot] <= cfg.code;
    end
  end

  assign code = layout[dec.slot];

  glyph_rom rom0 (
    .row    (dec.row),
    .col    (dec.col),
    .select (code),
    .word   (rom_bit)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      exe_valid <= 1'b0;
    end else begin
      exe_valid <= dec_valid;
    end
  end

  // Out-of-range pixels are forced dark
  always_ff @(posedge clk) begin
    exe.x   <= dec.x;
    exe.y   <= dec.y;
    exe.lit <= rom_bit & dec.in_range;
  end

  a_idx_in_glyph: assert property (@(posedge clk) disable iff (rst)
    dec_valid && dec.in_range |->
      dec.row <= 5'd19 && dec.col <= 5'd19)
    else $error("execute: glyph index out of range row=%0d col=%0d", dec.row, dec.col);

  // Nothing leaves the stage right after reset
  a_quiet_after_rst: assert property (@(posedge clk)
    rst |=> !exe_valid)
    else $error("execute: exe_valid set in the cycle after reset");

endmodule

`default_nettype wire

// File: design/pixel_result.sv
/* Result stage
   Registers the rendered pixel and keeps a wrapping count of lit pixels */
`default_nettype none

module pixel_result (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   exe_valid,
  input  banner_pkg::pix_res_t   exe,
  output logic                   res_valid,
  output banner_pkg::pix_res_t   res,
  output banner_pkg::lit_count_t lit_count
);

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= exe_valid;
    end
  end

  always_ff @(posedge clk) begin
    res <= exe;
  end

  // Counter moves on the same edge that presents the lit result
  always_ff @(posedge clk) begin
    if (rst) begin
      lit_count <= '0;
    end else if (exe_valid && exe.lit) begin
      lit_count <= lit_count + 1'b1;
    end
  end

  a_count_only_on_lit: assert property (@(posedge clk) disable iff (rst)
    $changed(lit_count) |-> res_valid && res.lit)
    else $error("result: lit_count moved without a lit result");

endmodule

`default_nettype wire

// File: design/banner_top.sv
/* Banner renderer top
   Decode, execute and result stages in a fixed 3-cycle pixel pipeline */
`default_nettype none

module banner_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req_valid,
  input  banner_pkg::pix_req_t   req,
  input  logic                   cfg_valid,
  input  banner_pkg::layout_wr_t cfg,
  output logic                   res_valid,
  output banner_pkg::pix_res_t   res,
  output banner_pkg::lit_count_t lit_count
);

  // Decode to execute
  logic                 dec_valid;
  banner_pkg::pix_dec_t dec;

  // Execute to result
  logic                 exe_valid;
  banner_pkg::pix_res_t exe;

  pixel_decode decode0 (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .dec_valid (dec_valid),
    .dec       (dec)
  );

  glyph_execute execute0 (
    .clk       (clk),
    .rst       (rst),
    .cfg_valid (cfg_valid),
    .cfg       (cfg),
    .dec_valid (dec_valid),
    .dec       (dec),
    .exe_valid (exe_valid),
    .exe       (exe)
  );

  pixel_result result0 (
    .clk       (clk),
    .rst       (rst),
    .exe_valid (exe_valid),
    .exe       (exe),
    .res_valid (res_valid),
    .res       (res),
    .lit_count (lit_count)
  );

endmodule

`default_nettype wire

// File: test/banner_glyphs.svh
/* Reference glyph bitmaps
   One row of every drawn glyph per lookup, packed as {code 0, code 1, code 3} */
`ifndef BANNER_GLYPHS_SVH
`define BANNER_GLYPHS_SVH

// Leftmost pixel of each glyph row is the MSB of its 20-bit field
function automatic logic [59:0] glyph_rows(input int row);
  logic [59:0] rows;
  case (row)
    0:  rows = {20'b00000000000000000000, 20'b00000000000000000000,
                20'b00000000000000101010};
    1:  rows = {20'b00000111111111100000, 20'b00100011101110111000,
                20'b00001000010000101010};
    2:  rows = {20'b00011000000000011000, 20'b00100010101000100000,
                20'b00111100111100110110};
    3:  rows = {20'b00100000000000000100, 20'b00100010101110111000,
                20'b01100111100110000000};
    4:  rows = {20'b01000111000011100010, 20'b00100010100010100000,
                20'b01000011000110011100};
    5:  rows = {20'b01001000100100010010, 20'b00111011101110111000,
                20'b00110000001100001000};
    6:  rows = {20'b01000000000000000010, 20'b00000000000000000000,
                20'b00011100111000011100};
    7:  rows = {20'b01000100000000100010, 20'b00001110000001110000,
                20'b00000111100000000000};
    8:  rows = {20'b00100011111111000100, 20'b00011111000011111000,
                20'b00000011000000110100};
    9:  rows = {20'b00011000000000011000, 20'b00011111110001111000,
                20'b00000010000000101100};
    10: rows = {20'b00000111111111100000, 20'b00001111100111110000,
                20'b00000000000000100100};
    11: rows = {20'b00000000000000000000, 20'b00000011110001100000,
                20'b00111000001110000001};
    12: rows = {20'b00000000000000000000, 20'b00000001100001000000,
                20'b01000100010001000001};
    13: rows = {20'b00011111000011110000, 20'b00000000100000000000,
                20'b01000100010001000010};
    14: rows = {20'b00100000000100001000, 20'b00011110000000000000,
                20'b01000100010001000010};
    15: rows = {20'b00100000001000000100, 20'b00100000111100100100,
                20'b01000100010001000100};
    16: rows = {20'b00100111101000000100, 20'b00011100100010100100,
                20'b01000100010001000100};
    17: rows = {20'b00100011000100001000, 20'b00000010111100011100,
                20'b01000100010001001000};
    18: rows = {20'b00011110000011110000, 20'b00000010100010000100,
                20'b01000100010001001000};
    19: rows = {20'b00000000000000000000, 20'b00111100100010011000,
                20'b00111001001110010000};
    // Rows below the banner are dark
    default: rows = '0;
  endcase
  return rows;
endfunction

`endif

// File: test/banner_tb.sv
/* Banner renderer testbench
   Scans and random pixels against a bitmap model, checking payload, latency and lit count */
`default_nettype none

module banner_tb;
  timeunit 1ns;
  timeprecision 1ps;

  `include "banner_glyphs.svh"

  localparam int CLK_PERIOD = 20;
  localparam int LATENCY    = 3;
  localparam int NUM_RANDOM = 500;
  // Slot 0 scan, two full banner scans, random pixels
  localparam int TOTAL_REQS = 400 + 2 * 1600 + NUM_RANDOM;

  typedef banner_pkg::glyph_code_t [banner_pkg::NUM_SLOTS-1:0] layout_t;

  typedef struct packed {
    banner_pkg::coord_x_t x;
    banner_pkg::coord_y_t y;
    logic                 lit;
    logic [63:0]          stamp;
  } expect_t;

  logic                   clk;
  logic                   rst;
  logic                   req_valid;
  banner_pkg::pix_req_t   req;
  logic                   cfg_valid;
  banner_pkg::layout_wr_t cfg;
  logic                   res_valid;
  banner_pkg::pix_res_t   res;
  banner_pkg::lit_count_t lit_count;

  layout_t    layout_model;
  expect_t    pending [$];
  int         model_lit;
  integer     seed;

  banner_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .cfg_valid (cfg_valid),
    .cfg       (cfg),
    .res_valid (res_valid),
    .res       (res),
    .lit_count (lit_count)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Expected pixel from the layout and the bitmap table
  function automatic logic expected_lit(input layout_t layout, input banner_pkg::pix_req_t r);
    int          slot;
    int          col;
    logic [59:0] rows;
    logic [19:0] line;
    if (r.x >= banner_pkg::BANNER_W || r.y >= banner_pkg::GLYPH_SIZE) begin
      return 1'b0;
    end
    slot = r.x / banner_pkg::GLYPH_SIZE;
    col  = r.x % banner_pkg::GLYPH_SIZE;
    rows = glyph_rows(r.y);
    case (layout[slot])
      2'd0:    line = rows[59:40];
      2'd1:    line = rows[39:20];
      2'd3:    line = rows[19:0];
      default: line = '0;
    endcase
    return line[banner_pkg::GLYPH_SIZE - 1 - col];
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error: %s is %0h, expected %0h", name, got, exp);
      $display("Some tests failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic write_slot(input banner_pkg::slot_t slot, input banner_pkg::glyph_code_t code);
    @(negedge clk);
    cfg_valid = 1'b1;
    cfg.slot  = slot;
    cfg.code  = code;
    layout_model[slot] = code;
    @(negedge clk);
    cfg_valid = 1'b0;
  endtask

  task automatic send_pixel(input banner_pkg::coord_x_t x, input banner_pkg::coord_y_t y);
    banner_pkg::pix_req_t r;
    expect_t              e;
    r.x = x;
    r.y = y;
    @(negedge clk);
    req_valid = 1'b1;
    req       = r;
    e.x     = x;
    e.y     = y;
    e.lit   = expected_lit(layout_model, r);
    e.stamp = $time;
    pending.push_back(e);
  endtask

  // Stop requesting and wait until every result is back
  task automatic drain;
    @(negedge clk);
    req_valid = 1'b0;
    while (pending.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
  endtask

  task automatic scan_region(input int x_lo, input int x_hi, input int y_lo, input int y_hi);
    for (int y = y_lo; y <= y_hi; y++) begin
      for (int x = x_lo; x <= x_hi; x++) begin
        send_pixel(banner_pkg::coord_x_t'(x), banner_pkg::coord_y_t'(y));
      end
    end
    drain();
  endtask

  // Scoreboard, one entry per result in request order
  initial begin : compare_results
    expect_t e;
    forever begin
      @(negedge clk);
      if (!rst && res_valid) begin
        if (pending.size() == 0) begin
          $display("A result came out with no request waiting for it");
          $display("Some tests failed");
          $fatal(1, "unexpected result");
        end else begin
          e = pending.pop_front();
          check_value("res.x", res.x, e.x);
          check_value("res.y", res.y, e.y);
          check_value("res.lit", res.lit, e.lit);
          check_value("latency", ($time - e.stamp) / CLK_PERIOD, LATENCY);
          if (e.lit) begin
            model_lit++;
          end
        end
      end
    end
  end

  initial begin : watchdog
    #((TOTAL_REQS + 100) * CLK_PERIOD);
    $display("The run timed out before all requests were answered");
    $display("Some tests failed");
    $fatal(1, "timeout");
  end

  initial begin : stimulus
    banner_pkg::coord_x_t rx;
    banner_pkg::coord_y_t ry;
    seed         = 32'hf1e0_e413;
    model_lit    = 0;
    rst          = 1'b1;
    req_valid    = 1'b0;
    req          = '0;
    cfg_valid    = 1'b0;
    cfg          = '0;
    layout_model = {banner_pkg::NUM_SLOTS{banner_pkg::CODE_BLANK}};

    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Quiet outputs after reset
    repeat (4) begin
      @(negedge clk);
      check_value("res_valid", res_valid, 1'b0);
      check_value("lit_count", lit_count, 16'h0);
    end

    // Blank layout renders nothing
    scan_region(0, 19, 0, 19);
    check_value("lit_count", lit_count, 16'h0);

    write_slot(2'd0, 2'd0);
    write_slot(2'd1, 2'd1);
    write_slot(2'd2, 2'd3);
    write_slot(2'd3, 2'd0);
    scan_region(0, banner_pkg::BANNER_W - 1, 0, banner_pkg::GLYPH_SIZE - 1);

    // Blank the third glyph only
    write_slot(2'd2, banner_pkg::CODE_BLANK);
    scan_region(0, banner_pkg::BANNER_W - 1, 0, banner_pkg::GLYPH_SIZE - 1);

    // Random pixels over the whole coordinate space, out of range included
    write_slot(2'd2, 2'd3);
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rx = banner_pkg::coord_x_t'($random(seed));
      ry = banner_pkg::coord_y_t'($random(seed));
      send_pixel(rx, ry);
    end
    drain();

    check_value("lit_count", lit_count, banner_pkg::lit_count_t'(model_lit));
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+test
design/banner_pkg.sv
design/glyph_rom.sv
design/pixel_decode.sv
design/glyph_execute.sv
design/pixel_result.sv
design/banner_top.sv
test/banner_tb.sv

// File: Bender.yml
package:
  name: banner_renderer

sources:
  - files:
      - design/banner_pkg.sv
      - design/glyph_rom.sv
      - design/pixel_decode.sv
      - design/glyph_execute.sv
      - design/pixel_result.sv
      - design/banner_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/banner_tb.sv
